// ==== hdl/rv_defs.svh ====
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// Integer data path width
`define RV_XLEN 32

// Architectural register count, x0 included
`define RV_REGS 32

// Data memory depth in 32-bit words
`define RV_DMEM_WORDS 64

`endif

// ==== hdl/rv_pkg.sv ====
`default_nettype none

`include "rv_defs.svh"

package rv_pkg;

    typedef enum logic [4:0] {
        LOAD   = 5'b00000,
        STORE  = 5'b01000,
        OP_IMM = 5'b00100,
        OP     = 5'b01100,
        LUI    = 5'b01101,
        AUIPC  = 5'b00101,
        BRANCH = 5'b11000, // Decoded, never executed
        JAL    = 5'b11011,
        JALR   = 5'b11001,
        SYSTEM = 5'b11100
    } OpCode;

    typedef logic [4:0] RegAddr;

    typedef enum logic [1:0] {
        BYTE = 2'b00,
        HALF = 2'b01,
        WORD = 2'b10,
        BAD  = 2'b11
    } MemWidth;

    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
        PASSB // Used by LUI
    } AluOp;

    // Load/store view of funct3
    typedef struct packed {
        logic    isUnsigned;
        MemWidth width;
    } Funct3;

    typedef struct packed {
        logic [6:0] funct7;
        RegAddr     rs2;
        RegAddr     rs1;
        logic [2:0] funct3;
        RegAddr     rd;
        OpCode      opCode;
        logic [1:0] lowBits; // Must be 2'b11
    } RInstr;

    typedef struct packed {
        logic [11:0] imm;
        RegAddr      rs1;
        Funct3       funct3;
        RegAddr      rd;
        OpCode       opCode;
        logic [1:0]  lowBits;
    } IInstr;

    typedef struct packed {
        logic [6:0] immHi;
        RegAddr     rs2;
        RegAddr     rs1;
        Funct3      funct3;
        logic [4:0] immLo;
        OpCode      opCode;
        logic [1:0] lowBits;
    } SInstr;

    typedef struct packed {
        logic [19:0] imm;
        RegAddr      rd;
        OpCode       opCode;
        logic [1:0]  lowBits;
    } UInstr;

    typedef union packed {
        RInstr r;
        IInstr i;
        SInstr s;
        UInstr u;
    } InstrWord;

    typedef struct packed {
        AluOp                aluOp;
        RegAddr              rs1;
        RegAddr              rs2;
        RegAddr              rd;          // Zero unless writesRd
        logic [`RV_XLEN-1:0] imm;         // Sign-extended
        logic                useImm;
        logic                usePcAsA;
        logic                writesRd;
        logic                isLoad;
        logic                isStore;
        MemWidth             memWidth;
        logic                memUnsigned;
        logic                illegal;
    } DecodedInstr;

    typedef struct packed {
        logic [`RV_XLEN-1:0] pc;
        InstrWord            instr;
    } IssueReq;

    typedef struct packed {
        logic [`RV_XLEN-1:0] pc;
        RegAddr              rd;
        logic [`RV_XLEN-1:0] data;       // Zero when nothing was written
        logic                wrote;
        logic                stored;
        logic                illegal;
        logic                misaligned;
    } WbResult;

endpackage

`default_nettype wire

// ==== hdl/instr_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rv_defs.svh"

module instr_decode (
    input  rv_pkg::InstrWord    instr,
    output rv_pkg::DecodedInstr dec
);
    import rv_pkg::*;

    logic [`RV_XLEN-1:0] immI;
    logic [`RV_XLEN-1:0] immS;
    logic [`RV_XLEN-1:0] immU;
    AluOp                funcOp;
    logic                altBit;

    assign immI = {{(`RV_XLEN-12){instr.i.imm[11]}}, instr.i.imm};
    assign immS = {{(`RV_XLEN-12){instr.s.immHi[6]}}, instr.s.immHi, instr.s.immLo};
    assign immU = {instr.u.imm, 12'b0};
    assign altBit = instr.r.funct7[5]; // Instruction bit 30

    always_comb begin
        unique case (instr.r.funct3)
            3'b000:  funcOp = (instr.r.opCode == OP && altBit) ? SUB : ADD; // ADDI has no SUB
            3'b001:  funcOp = SLL;
            3'b010:  funcOp = SLT;
            3'b011:  funcOp = SLTU;
            3'b100:  funcOp = XOR;
            3'b101:  funcOp = altBit ? SRA : SRL; // Same for OP and OP_IMM
            3'b110:  funcOp = OR;
            3'b111:  funcOp = AND;
        endcase
    end

    always_comb begin
        dec             = '0;
        dec.aluOp       = ADD;
        dec.rs1         = instr.r.rs1;
        dec.rs2         = instr.r.rs2;
        dec.memWidth    = instr.i.funct3.width;
        dec.memUnsigned = instr.i.funct3.isUnsigned;

        case (instr.r.opCode)
            LOAD: begin
                dec.imm      = immI;
                dec.useImm   = 1'b1;
                dec.writesRd = 1'b1;
                dec.isLoad   = 1'b1;
                dec.illegal  = (instr.i.funct3.width == BAD);
            end
            STORE: begin
                dec.imm     = immS; // Address only, rs2 carries the data
                dec.useImm  = 1'b1;
                dec.isStore = 1'b1;
                dec.illegal = (instr.s.funct3.width == BAD);
            end
            OP_IMM: begin
                dec.aluOp    = funcOp;
                dec.imm      = immI;
                dec.useImm   = 1'b1;
                dec.writesRd = 1'b1;
            end
            OP: begin
                dec.aluOp    = funcOp;
                dec.writesRd = 1'b1;
            end
            LUI: begin
                dec.aluOp    = PASSB;
                dec.imm      = immU;
                dec.useImm   = 1'b1;
                dec.writesRd = 1'b1;
            end
            AUIPC: begin
                dec.imm      = immU;
                dec.useImm   = 1'b1;
                dec.usePcAsA = 1'b1;
                dec.writesRd = 1'b1;
            end
            default: dec.illegal = 1'b1; // Control flow, SYSTEM and unknown codes
        endcase

        if (instr.r.lowBits != 2'b11) begin
            dec.illegal = 1'b1; // Compressed or garbage encoding
        end

        if (dec.writesRd) begin
            dec.rd = instr.r.rd;
        end

        // An illegal word must not touch any state
        if (dec.illegal) begin
            dec.writesRd = 1'b0;
            dec.isLoad   = 1'b0;
            dec.isStore  = 1'b0;
            dec.rd       = '0;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/reg_file.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rv_defs.svh"

module reg_file (
    input  logic                clk,
    input  logic                rstN,
    input  rv_pkg::RegAddr      rs1,
    input  rv_pkg::RegAddr      rs2,
    output logic [`RV_XLEN-1:0] rs1Data,
    output logic [`RV_XLEN-1:0] rs2Data,
    input  logic                wrEn,
    input  rv_pkg::RegAddr      wrAddr,
    input  logic [`RV_XLEN-1:0] wrData
);
    import rv_pkg::*;

    logic [`RV_XLEN-1:0] regs [`RV_REGS];

    assign rs1Data = regs[rs1]; // Old value until the write edge
    assign rs2Data = regs[rs2];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `RV_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrAddr != RegAddr'(0)) begin
            regs[wrAddr] <= wrData; // x0 stays hardwired
        end
    end

    // x0 reads as zero on both ports
    x0ReadsZero: assert property (
        @(posedge clk) disable iff (!rstN)
        (rs1 != RegAddr'(0) || rs1Data == '0) && (rs2 != RegAddr'(0) || rs2Data == '0)
    );

endmodule

`default_nettype wire

// ==== hdl/int_alu.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rv_defs.svh"

module int_alu (
    input  rv_pkg::AluOp        op,
    input  logic [`RV_XLEN-1:0] a,
    input  logic [`RV_XLEN-1:0] b,
    output logic [`RV_XLEN-1:0] result
);
    import rv_pkg::*;

    logic [4:0] shamt;
    logic       ltSigned;
    logic       ltUnsigned;

    assign shamt      = b[4:0]; // Upper bits of b ignored
    assign ltSigned   = $signed(a) < $signed(b);
    assign ltUnsigned = a < b;

    always_comb begin
        case (op)
            ADD:     result = a + b;
            SUB:     result = a - b;
            SLL:     result = a << shamt;
            SLT:     result = {{(`RV_XLEN-1){1'b0}}, ltSigned};
            SLTU:    result = {{(`RV_XLEN-1){1'b0}}, ltUnsigned};
            XOR:     result = a ^ b;
            SRL:     result = a >> shamt;
            SRA:     result = $unsigned($signed(a) >>> shamt); // Sign bit fills
            OR:      result = a | b;
            AND:     result = a & b;
            PASSB:   result = b;
            default: result = '0; // Unused encodings
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/load_store_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rv_defs.svh"

module load_store_unit (
    input  logic                clk,
    input  logic                rstN,
    input  logic [`RV_XLEN-1:0] addr,
    input  rv_pkg::MemWidth     width,
    input  logic                isUnsigned,
    input  logic                isAccess,
    input  logic                storeEn,
    input  logic [`RV_XLEN-1:0] storeData,
    output logic [`RV_XLEN-1:0] loadData,
    output logic                misaligned
);
    import rv_pkg::*;

    localparam int IdxW = $clog2(`RV_DMEM_WORDS);

    logic [`RV_XLEN-1:0] mem [`RV_DMEM_WORDS];
    logic [IdxW-1:0]     wordIdx;
    logic [1:0]          byteOff;
    logic [3:0]          laneMask;
    logic [`RV_XLEN-1:0] laneData;  // Store data moved onto its lanes
    logic [`RV_XLEN-1:0] wordOut;   // Addressed lane moved down to bit 0

    assign wordIdx  = addr[IdxW+1:2]; // Wraps at memory depth
    assign byteOff  = addr[1:0];
    assign laneData = storeData << (8 * byteOff);
    assign wordOut  = mem[wordIdx] >> (8 * byteOff);

    always_comb begin
        case (width)
            BYTE:    laneMask = 4'b0001 << byteOff;
            HALF:    laneMask = 4'b0011 << byteOff;
            default: laneMask = 4'b1111;
        endcase
    end

    assign misaligned = isAccess &&
                        ((width == HALF && byteOff[0]) || (width == WORD && byteOff != 2'b00));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int w = 0; w < `RV_DMEM_WORDS; w++) begin
                mem[w] <= '0;
            end
        end else if (storeEn) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (laneMask[lane]) begin
                    mem[wordIdx][8*lane +: 8] <= laneData[8*lane +: 8];
                end
            end
        end
    end

    always_comb begin
        case (width)
            BYTE:    loadData = {{24{wordOut[7] & ~isUnsigned}}, wordOut[7:0]};
            HALF:    loadData = {{16{wordOut[15] & ~isUnsigned}}, wordOut[15:0]};
            default: loadData = mem[wordIdx];
        endcase
    end

    // The top must block any store that fails the alignment check here
    noMisalignedStore: assert property (
        @(posedge clk) disable iff (!rstN) storeEn |-> !misaligned
    );

endmodule

`default_nettype wire

// ==== hdl/rv_exec_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rv_defs.svh"

module rv_exec_top (
    input  logic            clk,
    input  logic            rstN,
    input  logic            inValid,
    output logic            inReady,
    input  rv_pkg::IssueReq inReq,
    output logic            wbValid,
    input  logic            wbReady,
    output rv_pkg::WbResult wb
);
    import rv_pkg::*;

    DecodedInstr         dec;
    logic [`RV_XLEN-1:0] rs1Data;
    logic [`RV_XLEN-1:0] rs2Data;
    logic [`RV_XLEN-1:0] opA;
    logic [`RV_XLEN-1:0] opB;
    logic [`RV_XLEN-1:0] aluResult;
    logic [`RV_XLEN-1:0] loadData;
    logic [`RV_XLEN-1:0] wrValue;
    logic                misaligned;
    logic                accept;
    logic                commitOk;  // Instruction may change state
    logic                regWrEn;
    logic                storeEn;

    assign inReady  = !wbValid || wbReady; // Output slot free or draining
    assign accept   = inValid && inReady;
    assign commitOk = !dec.illegal && !misaligned;
    assign regWrEn  = accept && dec.writesRd && commitOk;
    assign storeEn  = accept && dec.isStore && commitOk;

    assign opA     = dec.usePcAsA ? inReq.pc : rs1Data;
    assign opB     = dec.useImm ? dec.imm : rs2Data;
    assign wrValue = dec.isLoad ? loadData : aluResult;

    instr_decode uDecode (.instr(inReq.instr), .dec(dec));

    reg_file uRegs (
        .clk, .rstN,
        .rs1(dec.rs1), .rs2(dec.rs2), .rs1Data, .rs2Data,
        .wrEn(regWrEn), .wrAddr(dec.rd), .wrData(wrValue)
    );

    int_alu uAlu (.op(dec.aluOp), .a(opA), .b(opB), .result(aluResult));

    load_store_unit uLsu (
        .clk, .rstN,
        .addr(aluResult), .width(dec.memWidth), .isUnsigned(dec.memUnsigned),
        .isAccess(dec.isLoad || dec.isStore), .storeEn, .storeData(rs2Data),
        .loadData, .misaligned
    );

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wbValid <= 1'b0;
        end else if (accept) begin
            wbValid <= 1'b1;
        end else if (wbReady) begin
            wbValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            wb.pc         <= inReq.pc;
            wb.rd         <= dec.rd;
            wb.data       <= (dec.writesRd && commitOk) ? wrValue : '0;
            wb.wrote      <= dec.writesRd && commitOk; // Set for x0 too
            wb.stored     <= dec.isStore && commitOk;
            wb.illegal    <= dec.illegal;
            wb.misaligned <= misaligned;
        end
    end

    // Stalled result must stay put until the consumer takes it
    wbHeldOnStall: assert property (
        @(posedge clk) disable iff (!rstN)
        wbValid && !wbReady |=> wbValid && $stable(wb)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_rv_exec.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rv_defs.svh"

module tb_rv_exec;
    import rv_pkg::*;

    localparam int NumInstr    = 400;
    localparam int ResetCycles = 16;
    localparam int ClkPeriod   = 10;

    logic    clk;
    logic    rstN;
    logic    inValid;
    logic    inReady;
    IssueReq inReq;
    logic    wbValid;
    logic    wbReady;
    WbResult wb;

    logic [`RV_XLEN-1:0] modelRegs [`RV_REGS];
    logic [`RV_XLEN-1:0] modelMem [`RV_DMEM_WORDS];
    WbResult             expQ [$];
    WbResult             heldWb;   // Result seen at the start of a stall
    logic                stallSeen;
    integer              seed;
    integer              readySeed;
    int                  sentCount;
    int                  doneCount;
    int                  checkCount;
    int                  errorCount;

    rv_exec_top uut (.clk, .rstN, .inValid, .inReady, .inReq, .wbValid, .wbReady, .wb);

    always #(ClkPeriod / 2) clk = ~clk;

    // Reference ALU, bit 30 picks SUB only for register ops
    function automatic logic [31:0] aluModel(input logic [2:0] f3, input logic alt,
                                             input logic isReg, input logic [31:0] a,
                                             input logic [31:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            3'd0:    return (isReg && alt) ? a - b : a + b;
            3'd1:    return a << sh;
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? $unsigned($signed(a) >>> sh) : a >> sh;
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // Expected result of one accepted instruction, model state updated as it retires
    task automatic predictResult(input IssueReq req, output WbResult res);
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immI;
        logic [31:0] immS;
        logic [31:0] immU;
        logic [31:0] addr;
        logic [31:0] val;
        logic [31:0] word;
        logic [1:0]  off;
        logic        writes;
        int          idx;
        w      = req.instr;
        a      = modelRegs[w[19:15]];
        b      = modelRegs[w[24:20]];
        immI   = {{20{w[31]}}, w[31:20]};
        immS   = {{20{w[31]}}, w[31:25], w[11:7]};
        immU   = {w[31:12], 12'b0};
        res    = '0;
        res.pc = req.pc;
        writes = 1'b0;
        val    = '0;
        if (w[1:0] != 2'b11) begin
            res.illegal = 1'b1;
        end else begin
            case (w[6:2])
                5'b01100: begin
                    val    = aluModel(w[14:12], w[30], 1'b1, a, b);
                    writes = 1'b1;
                end
                5'b00100: begin
                    val    = aluModel(w[14:12], w[30], 1'b0, a, immI);
                    writes = 1'b1;
                end
                5'b01101: begin
                    val    = immU;
                    writes = 1'b1;
                end
                5'b00101: begin
                    val    = req.pc + immU;
                    writes = 1'b1;
                end
                5'b00000, 5'b01000: begin
                    if (w[13:12] == 2'b11) begin
                        res.illegal = 1'b1;
                    end else begin
                        addr = a + ((w[6:2] == 5'b00000) ? immI : immS);
                        off  = addr[1:0];
                        idx  = int'((addr >> 2) % `RV_DMEM_WORDS);
                        res.misaligned = (w[13:12] == 2'b01 && off[0]) ||
                                         (w[13:12] == 2'b10 && off != 2'b00);
                        if (w[6:2] == 5'b00000) begin
                            res.rd = w[11:7]; // Reported even when misaligned
                            word   = modelMem[idx] >> (8 * off);
                            case (w[13:12])
                                2'b00:   val = {{24{word[7] & ~w[14]}}, word[7:0]};
                                2'b01:   val = {{16{word[15] & ~w[14]}}, word[15:0]};
                                default: val = modelMem[idx];
                            endcase
                            writes = !res.misaligned;
                        end else if (!res.misaligned) begin
                            case (w[13:12])
                                2'b00:   modelMem[idx][8*off +: 8] = b[7:0];
                                2'b01:   modelMem[idx][8*off +: 16] = b[15:0];
                                default: modelMem[idx] = b;
                            endcase
                            res.stored = 1'b1;
                        end
                    end
                end
                default: res.illegal = 1'b1;
            endcase
        end
        if (writes) begin
            res.wrote = 1'b1;
            res.rd    = w[11:7];
            res.data  = val;
            if (w[11:7] != 5'd0) begin
                modelRegs[w[11:7]] = val;
            end
        end
    endtask

    // Random instruction from the kept mix, first few are loads from fresh memory
    task automatic makeInstr(input int n, output logic [31:0] w);
        logic [31:0] r;
        logic [31:0] r2;
        logic [4:0]  rd;
        logic [4:0]  base;
        logic [2:0]  f3;
        logic [11:0] imm;
        int          kind;
        r    = $random(seed);
        r2   = $random(seed);
        kind = (n < 8) ? 11 : int'(r2[31:24]) % 20;
        rd   = (r[27:25] == 3'b000) ? 5'd0 : r[4:0]; // Extra x0 writes
        f3   = r[17:15];
        base = (r[19:18] == 2'b00) ? {2'b00, r[22:20]} : 5'd0;
        imm  = {4'h0, r2[7:0]};
        if (kind < 5) begin
            w = {1'b0, r[18], 5'b00000, r[14:10], r[9:5], f3, rd, 5'b01100, 2'b11};
        end else if (kind < 9) begin
            if (f3[1:0] == 2'b01) begin
                imm = {1'b0, r[18], 5'b00000, r2[4:0]};
            end else begin
                imm = r2[11:0];
            end
            w = {imm, r[9:5], f3, rd, 5'b00100, 2'b11};
        end else if (kind < 11) begin
            w = {r2[31:12], rd, (kind == 9) ? 5'b01101 : 5'b00101, 2'b11};
        end else if (kind < 18) begin
            if (kind < 15) begin
                f3 = (f3 == 3'b110) ? 3'b010 : f3 & {1'b1, ~(f3[1] & f3[0]), 1'b1};
            end else begin
                f3 = {1'b0, r[16] & ~r[15], r[15]};
            end
            if (r2[11:8] != 4'h0) begin
                imm[0] = imm[0] & ~f3[0] & ~f3[1];
                imm[1] = imm[1] & ~f3[1];
            end
            if (kind < 15) begin
                w = {imm, base, f3, rd, 5'b00000, 2'b11};
            end else begin
                w = {imm[11:5], r[14:10], base, f3, imm[4:0], 5'b01000, 2'b11};
            end
        end else if (kind == 18) begin
            w = r2;
            if (r[18]) begin
                w[1:0] = {r[19], ~r[19]};
            end else begin
                w[6:0] = {r[21] ? 3'b110 : 3'b111, r[20], r[21] | r[20], 2'b11};
            end
        end else begin
            w = {imm, base, r[15], 2'b11, rd, r[16] ? 5'b00000 : 5'b01000, 2'b11};
        end
    endtask

    task automatic checkField(input string what, input int idx, input logic [31:0] expV,
                              input logic [31:0] actV);
        checkCount++;
        if (actV !== expV) begin
            errorCount++;
            $display("CHECK FAILED result %0d %s: expected %h, actual %h",
                     idx, what, expV, actV);
        end
    endtask

    task automatic compareResult(input int idx, input WbResult expRes, input WbResult act);
        checkField("pc", idx, expRes.pc, act.pc);
        checkField("rd", idx, 32'(expRes.rd), 32'(act.rd));
        checkField("data", idx, expRes.data, act.data);
        checkField("wrote", idx, 32'(expRes.wrote), 32'(act.wrote));
        checkField("stored", idx, 32'(expRes.stored), 32'(act.stored));
        checkField("illegal", idx, 32'(expRes.illegal), 32'(act.illegal));
        checkField("misaligned", idx, 32'(expRes.misaligned), 32'(act.misaligned));
    endtask

    // Everything is sampled mid-cycle, where DUT outputs and driven inputs are settled
    always @(negedge clk) begin
        WbResult expRes;
        if (rstN) begin
            if (stallSeen && !wbValid) begin
                errorCount++;
                $display("wbValid dropped while the result was held back");
            end else if (stallSeen && wb !== heldWb) begin
                errorCount++;
                $display("CHECK FAILED stall hold: expected %h, actual %h", heldWb, wb);
            end
            if (wbValid && wbReady) begin
                if (expQ.size() == 0) begin
                    errorCount++;
                    $display("A result came out with no instruction outstanding");
                end else begin
                    expRes = expQ.pop_front();
                    compareResult(doneCount, expRes, wb);
                end
                doneCount++;
            end
            if (inValid && inReady) begin
                predictResult(inReq, expRes);
                expQ.push_back(expRes);
                sentCount++;
            end
            stallSeen = wbValid && !wbReady;
            if (stallSeen) begin
                heldWb = wb;
                checkField("inReady low on stall", doneCount, 32'd0, 32'(inReady));
            end
        end
    end

    initial begin
        logic [31:0] instrWord;
        logic [31:0] pcVal;
        logic        took;
        clk        = 1'b0;
        rstN       = 1'b0;
        inValid    = 1'b0;
        inReq      = '0;
        wbReady    = 1'b0;
        seed       = 32'ha527;
        readySeed  = seed + 1;
        stallSeen  = 1'b0;
        sentCount  = 0;
        doneCount  = 0;
        checkCount = 0;
        errorCount = 0;
        pcVal      = 32'h0000_1000;
        for (int i = 0; i < `RV_REGS; i++) begin
            modelRegs[i] = '0;
        end
        for (int i = 0; i < `RV_DMEM_WORDS; i++) begin
            modelMem[i] = '0;
        end
        repeat (ResetCycles) @(posedge clk);
        #1 rstN = 1'b1;
        @(negedge clk);
        checkField("wbValid after reset", 0, 32'd0, 32'(wbValid));
        checkField("inReady after reset", 0, 32'd1, 32'(inReady));
        @(posedge clk);
        #1;
        for (int n = 0; n < NumInstr; n++) begin
            while (($random(seed) & 3) == 0) begin
                @(posedge clk); // Idle gap
                #1;
            end
            makeInstr(n, instrWord);
            inReq.pc    = pcVal;
            inReq.instr = instrWord;
            inValid     = 1'b1;
            do begin
                @(negedge clk);
                took = inReady;
                @(posedge clk);
                #1;
            end while (!took);
            inValid = 1'b0;
            pcVal   = pcVal + 32'd4;
        end
        wait (doneCount == NumInstr);
        repeat (4) @(posedge clk);
        if (expQ.size() != 0) begin
            errorCount++;
            $display("%0d results never came out", expQ.size());
        end
        $display("Summary: %0d sent, %0d retired, %0d checks, %0d errors",
                 sentCount, doneCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        wait (rstN === 1'b1);
        forever begin
            @(posedge clk);
            #1 wbReady = ($random(readySeed) & 3) != 0;
        end
    end

    // Watchdog sized for the worst pacing of every instruction
    initial begin
        #((ResetCycles + NumInstr * 40) * ClkPeriod);
        errorCount++;
        $display("Timeout: %0d of %0d results seen", doneCount, NumInstr);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+hdl
hdl/rv_pkg.sv
hdl/instr_decode.sv
hdl/reg_file.sv
hdl/int_alu.sv
hdl/load_store_unit.sv
hdl/rv_exec_top.sv
testbench/tb_rv_exec.sv

// ==== run.sh ====
#!/bin/sh
# Builds the RV32I execution slice testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f all.f --top-module tb_rv_exec -o tb_rv_exec
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_rv_exec > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q '\*\*\* FAILED \*\*\*' "$LOG"; then
    echo "Simulation reported a failure, see $LOG"
    exit 1
fi

echo "Simulation finished without failures"
exit 0
